//--- f2c_dma.f
logic/f2c_pkg.sv
logic/mem_wr_if.sv
logic/stream_fifo.sv
logic/burst_planner.sv
logic/f2c_ctrl.sv
logic/wr_port.sv
logic/f2c_dma.sv
verif/f2c_dma_tb.sv

//--- logic/burst_planner.sv
`timescale 1ns/1ps
`default_nettype none

module burst_planner (
  input  logic                clk,
  input  logic                rst,
  input  f2c_pkg::rb_size_t   pkt_rb_size,
  input  f2c_pkg::pkt_meta_t  meta,
  input  logic                load,
  input  logic                advance,
  output logic                first_beat,
  output logic                last_in_burst,
  output logic                pkt_done,
  output logic                queue_ok,
  output f2c_pkg::burst_t     burst_len,
  output f2c_pkg::addr_t      burst_addr,
  output f2c_pkg::addr_t      dsc_addr,
  output f2c_pkg::flit_t      dsc_word
);

  f2c_pkg::pkt_meta_t cur;
  f2c_pkg::rb_size_t  rb_size_r;
  f2c_pkg::rb_idx_t   rb_mask;
  f2c_pkg::rb_idx_t   tail;
  f2c_pkg::pkt_len_t  remaining;
  f2c_pkg::burst_t    in_left;
  f2c_pkg::rb_size_t  slots_left;
  f2c_pkg::pkt_len_t  len_wide;

  // Burst length is the smallest of what is left, MAX_BURST and room to the ring end
  always_comb begin
    slots_left = rb_size_r - {1'b0, tail};
    if (remaining > f2c_pkg::pkt_len_t'(f2c_pkg::MAX_BURST)) begin
      len_wide = f2c_pkg::pkt_len_t'(f2c_pkg::MAX_BURST);
    end else begin
      len_wide = remaining;
    end
    if (len_wide > f2c_pkg::pkt_len_t'(slots_left)) begin
      len_wide = f2c_pkg::pkt_len_t'(slots_left);
    end
    burst_len = f2c_pkg::burst_t'(len_wide);
  end

  // in_left counts beats still owed to the open burst, zero means none is open
  assign first_beat    = (in_left == '0);
  assign last_in_burst = first_beat ? (burst_len == 4'd1) : (in_left == 4'd1);
  assign pkt_done      = (remaining == 16'd1);
  assign queue_ok      = (cur.pkt_base != '0) && (cur.dsc_base != '0);

  assign burst_addr = cur.pkt_base
                    + f2c_pkg::addr_t'(tail) * f2c_pkg::addr_t'(f2c_pkg::FLIT_BYTES);
  assign dsc_addr   = cur.dsc_base
                    + f2c_pkg::addr_t'(cur.dsc_tail) * f2c_pkg::addr_t'(f2c_pkg::FLIT_BYTES);

  // Descriptor carries the tail after the last flit of the packet
  always_comb begin
    dsc_word = '0;
    dsc_word[0] = 1'b1;
    dsc_word[f2c_pkg::RB_AWIDTH:1] = tail;
    dsc_word[f2c_pkg::RB_AWIDTH+f2c_pkg::QID_W:f2c_pkg::RB_AWIDTH+1] = cur.queue_id;
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cur       <= meta;
      rb_size_r <= pkt_rb_size;
      rb_mask   <= pkt_rb_size[f2c_pkg::RB_AWIDTH-1:0] - 1'b1;
      tail      <= meta.pkt_tail;
    end else if (advance) begin
      tail <= (tail + 1'b1) & rb_mask;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
      in_left   <= '0;
    end else if (load) begin
      remaining <= meta.size;
      in_left   <= '0;
    end else if (advance) begin
      remaining <= remaining - 1'b1;
      in_left   <= first_beat ? (burst_len - 1'b1) : (in_left - 1'b1);
    end
  end

endmodule

`default_nettype wire

//--- logic/f2c_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module f2c_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  f2c_pkg::flit_t     flit_data,
  input  logic               flit_valid,
  output logic               flit_ready,
  input  f2c_pkg::pkt_meta_t meta,
  input  logic               meta_valid,
  output logic               meta_ready,
  output logic               load,
  output logic               advance,
  input  logic               first_beat,
  input  logic               last_in_burst,
  input  logic               pkt_done,
  input  logic               queue_ok,
  input  f2c_pkg::burst_t    burst_len,
  input  f2c_pkg::addr_t     burst_addr,
  input  f2c_pkg::addr_t     dsc_addr,
  input  f2c_pkg::flit_t     dsc_word,
  mem_wr_if.src              wr,
  output f2c_pkg::cnt_t      flit_cnt,
  output f2c_pkg::cnt_t      flit_drop_cnt,
  output f2c_pkg::cnt_t      dsc_cnt,
  output f2c_pkg::cnt_t      dsc_drop_cnt
);

  f2c_pkg::dma_state_t state;
  logic                needs_dsc;
  logic                in_pkt;
  logic                flit_go;
  logic                dsc_go;

  assign in_pkt  = (state == f2c_pkg::START_BURST) || (state == f2c_pkg::CONT_BURST);
  assign flit_go = in_pkt && flit_valid && !wr.waitrequest;
  assign dsc_go  = (state == f2c_pkg::SEND_DSC) && !wr.waitrequest;

  assign meta_ready = (state == f2c_pkg::IDLE);
  assign load       = meta_valid && meta_ready;

  // Flits of a dropped packet still leave the FIFO, just without a write
  assign flit_ready = flit_go;
  assign advance    = flit_go;

  always_comb begin
    wr.write = (flit_go || dsc_go) && queue_ok;
    if (state == f2c_pkg::SEND_DSC) begin
      wr.addr       = dsc_addr;
      wr.data       = dsc_word;
      wr.burstcount = f2c_pkg::burst_t'(1);
    end else begin
      wr.addr = burst_addr;
      wr.data = flit_data;
      // Burst count only matters on the first beat
      wr.burstcount = first_beat ? burst_len : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      needs_dsc <= meta.needs_dsc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= f2c_pkg::IDLE;
    end else begin
      case (state)
        f2c_pkg::IDLE: begin
          if (load) begin
            state <= f2c_pkg::START_BURST;
          end
        end
        f2c_pkg::START_BURST, f2c_pkg::CONT_BURST: begin
          if (flit_go) begin
            if (pkt_done) begin
              state <= needs_dsc ? f2c_pkg::SEND_DSC : f2c_pkg::IDLE;
            end else if (last_in_burst) begin
              state <= f2c_pkg::START_BURST;
            end else begin
              state <= f2c_pkg::CONT_BURST;
            end
          end
        end
        f2c_pkg::SEND_DSC: begin
          if (dsc_go) begin
            state <= f2c_pkg::IDLE;
          end
        end
        default: begin
          state <= f2c_pkg::IDLE;
        end
      endcase
    end
  end

  // Written and dropped counts, split by the queue addresses
  always_ff @(posedge clk) begin
    if (rst) begin
      flit_cnt      <= '0;
      flit_drop_cnt <= '0;
      dsc_cnt       <= '0;
      dsc_drop_cnt  <= '0;
    end else begin
      if (flit_go) begin
        if (queue_ok) begin
          flit_cnt <= flit_cnt + 1'b1;
        end else begin
          flit_drop_cnt <= flit_drop_cnt + 1'b1;
        end
      end
      if (dsc_go) begin
        if (queue_ok) begin
          dsc_cnt <= dsc_cnt + 1'b1;
        end else begin
          dsc_drop_cnt <= dsc_drop_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/f2c_dma.sv
`timescale 1ns/1ps
`default_nettype none

module f2c_dma (
  input  logic               clk,
  input  logic               rst,

  input  f2c_pkg::flit_t     flit_in_data,
  input  logic               flit_in_valid,
  output logic               flit_in_ready,

  input  f2c_pkg::pkt_meta_t meta_in_data,
  input  logic               meta_in_valid,
  output logic               meta_in_ready,

  input  f2c_pkg::rb_size_t  pkt_rb_size,

  output f2c_pkg::addr_t     mem_addr,
  output f2c_pkg::flit_t     mem_data,
  output logic               mem_write,
  output f2c_pkg::burst_t    mem_burstcount,
  input  logic               mem_waitrequest,

  output f2c_pkg::cnt_t      flit_cnt,
  output f2c_pkg::cnt_t      flit_drop_cnt,
  output f2c_pkg::cnt_t      dsc_cnt,
  output f2c_pkg::cnt_t      dsc_drop_cnt,
  output f2c_pkg::cnt_t      stall_cnt
);

  f2c_pkg::flit_t     flit_q_data;
  logic               flit_q_valid;
  logic               flit_q_ready;
  f2c_pkg::pkt_meta_t meta_q_data;
  logic               meta_q_valid;
  logic               meta_q_ready;

  logic               load;
  logic               advance;
  logic               first_beat;
  logic               last_in_burst;
  logic               pkt_done;
  logic               queue_ok;
  f2c_pkg::burst_t    burst_len;
  f2c_pkg::addr_t     burst_addr;
  f2c_pkg::addr_t     dsc_addr;
  f2c_pkg::flit_t     dsc_word;

  mem_wr_if wr_bus ();

  stream_fifo #(
    .WIDTH ($bits(f2c_pkg::flit_t))
  ) flit_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (flit_in_data),
    .in_valid  (flit_in_valid),
    .in_ready  (flit_in_ready),
    .out_data  (flit_q_data),
    .out_valid (flit_q_valid),
    .out_ready (flit_q_ready)
  );

  stream_fifo #(
    .WIDTH ($bits(f2c_pkg::pkt_meta_t))
  ) meta_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (meta_in_data),
    .in_valid  (meta_in_valid),
    .in_ready  (meta_in_ready),
    .out_data  (meta_q_data),
    .out_valid (meta_q_valid),
    .out_ready (meta_q_ready)
  );

  burst_planner burst_planner_inst (
    .clk           (clk),
    .rst           (rst),
    .pkt_rb_size   (pkt_rb_size),
    .meta          (meta_q_data),
    .load          (load),
    .advance       (advance),
    .first_beat    (first_beat),
    .last_in_burst (last_in_burst),
    .pkt_done      (pkt_done),
    .queue_ok      (queue_ok),
    .burst_len     (burst_len),
    .burst_addr    (burst_addr),
    .dsc_addr      (dsc_addr),
    .dsc_word      (dsc_word)
  );

  f2c_ctrl f2c_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .flit_data     (flit_q_data),
    .flit_valid    (flit_q_valid),
    .flit_ready    (flit_q_ready),
    .meta          (meta_q_data),
    .meta_valid    (meta_q_valid),
    .meta_ready    (meta_q_ready),
    .load          (load),
    .advance       (advance),
    .first_beat    (first_beat),
    .last_in_burst (last_in_burst),
    .pkt_done      (pkt_done),
    .queue_ok      (queue_ok),
    .burst_len     (burst_len),
    .burst_addr    (burst_addr),
    .dsc_addr      (dsc_addr),
    .dsc_word      (dsc_word),
    .wr            (wr_bus.src),
    .flit_cnt      (flit_cnt),
    .flit_drop_cnt (flit_drop_cnt),
    .dsc_cnt       (dsc_cnt),
    .dsc_drop_cnt  (dsc_drop_cnt)
  );

  wr_port wr_port_inst (
    .clk             (clk),
    .rst             (rst),
    .wr              (wr_bus.dst),
    .mem_addr        (mem_addr),
    .mem_data        (mem_data),
    .mem_write       (mem_write),
    .mem_burstcount  (mem_burstcount),
    .mem_waitrequest (mem_waitrequest),
    .stall_cnt       (stall_cnt)
  );

endmodule

`default_nettype wire

//--- logic/f2c_pkg.sv
`default_nettype none

package f2c_pkg;

  localparam int FLIT_W     = 512;
  localparam int ADDR_W     = 64;
  localparam int RB_AWIDTH  = 10;
  localparam int MAX_BURST  = 8;
  localparam int FLIT_BYTES = 64;
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int QID_W      = 8;

  typedef logic [FLIT_W-1:0]    flit_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [RB_AWIDTH-1:0] rb_idx_t;
  typedef logic [RB_AWIDTH:0]   rb_size_t;
  typedef logic [3:0]           burst_t;
  typedef logic [15:0]          pkt_len_t;
  typedef logic [31:0]          cnt_t;

  // One entry of the metadata stream, one per packet
  typedef struct packed {
    pkt_len_t         size;
    addr_t            pkt_base;
    rb_idx_t          pkt_tail;
    addr_t            dsc_base;
    rb_idx_t          dsc_tail;
    logic [QID_W-1:0] queue_id;
    logic             needs_dsc;
  } pkt_meta_t;

  typedef enum logic [1:0] {
    IDLE,
    START_BURST,
    CONT_BURST,
    SEND_DSC
  } dma_state_t;

endpackage

`default_nettype wire

//--- logic/mem_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// One write beat on its way from the DMA control to the memory port
interface mem_wr_if;

  f2c_pkg::addr_t  addr;
  f2c_pkg::flit_t  data;
  logic            write;
  f2c_pkg::burst_t burstcount;
  logic            waitrequest;

  modport src (
    output addr, data, write, burstcount,
    input  waitrequest
  );

  modport dst (
    input  addr, data, write, burstcount,
    output waitrequest
  );

endinterface

`default_nettype wire

//--- logic/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic [WIDTH-1:0] mem [f2c_pkg::FIFO_DEPTH];

  logic [f2c_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [f2c_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [f2c_pkg::FIFO_PTR_W:0]   count;
  logic [f2c_pkg::FIFO_PTR_W:0]   count_next;
  logic                           push;
  logic                           pop;

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count    <= count_next;
      in_ready <= (count_next != (f2c_pkg::FIFO_PTR_W + 1)'(f2c_pkg::FIFO_DEPTH));
    end
  end

endmodule

`default_nettype wire

//--- logic/wr_port.sv
`timescale 1ns/1ps
`default_nettype none

module wr_port (
  input  logic            clk,
  input  logic            rst,
  mem_wr_if.dst           wr,
  output f2c_pkg::addr_t  mem_addr,
  output f2c_pkg::flit_t  mem_data,
  output logic            mem_write,
  output f2c_pkg::burst_t mem_burstcount,
  input  logic            mem_waitrequest,
  output f2c_pkg::cnt_t   stall_cnt
);

  // Upstream sees the same stall as the memory port
  assign wr.waitrequest = mem_waitrequest;

  // Holding stage loads only when the current beat is taken
  always_ff @(posedge clk) begin
    if (!mem_waitrequest) begin
      mem_addr       <= wr.addr;
      mem_data       <= wr.data;
      mem_burstcount <= wr.burstcount;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_write <= 1'b0;
    end else if (!mem_waitrequest) begin
      mem_write <= wr.write;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stall_cnt <= '0;
    end else if (mem_waitrequest) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f f2c_dma.f --top-module f2c_dma_tb -o f2c_dma_sim

out=$(./obj_dir/f2c_dma_sim)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

//--- verif/f2c_dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module f2c_dma_tb;

  localparam int CLK_PERIOD  = 10;
  localparam int DONE_LIMIT  = 400;
  // About 60 flits over all tests and half the cycles stalled in the last two packets
  localparam int WATCHDOG_NS = 20000;

  logic clk = 1'b0;
  logic rst = 1'b1;

  f2c_pkg::flit_t     flit_in_data = '0;
  logic               flit_in_valid = 1'b0;
  logic               flit_in_ready;
  f2c_pkg::pkt_meta_t meta_in_data = '0;
  logic               meta_in_valid = 1'b0;
  logic               meta_in_ready;
  f2c_pkg::rb_size_t  pkt_rb_size = '0;
  f2c_pkg::addr_t     mem_addr;
  f2c_pkg::flit_t     mem_data;
  logic               mem_write;
  f2c_pkg::burst_t    mem_burstcount;
  logic               mem_waitrequest = 1'b0;
  f2c_pkg::cnt_t      flit_cnt;
  f2c_pkg::cnt_t      flit_drop_cnt;
  f2c_pkg::cnt_t      dsc_cnt;
  f2c_pkg::cnt_t      dsc_drop_cnt;
  f2c_pkg::cnt_t      stall_cnt;

  // Beats seen on the memory port
  f2c_pkg::addr_t  got_addr[$];
  f2c_pkg::burst_t got_bc[$];
  f2c_pkg::flit_t  got_data[$];
  f2c_pkg::addr_t  cur_addr = '0;
  f2c_pkg::burst_t cur_bc = '0;
  int              beats_left = 0;
  f2c_pkg::cnt_t   stall_seen = '0;

  // Beats the reference model predicts
  f2c_pkg::addr_t  exp_addr[$];
  f2c_pkg::burst_t exp_bc[$];
  f2c_pkg::flit_t  exp_data[$];
  f2c_pkg::cnt_t   exp_flit_cnt = '0;
  f2c_pkg::cnt_t   exp_flit_drop = '0;
  f2c_pkg::cnt_t   exp_dsc_cnt = '0;
  f2c_pkg::cnt_t   exp_dsc_drop = '0;

  int     got_base = 0;
  int     next_flit = 0;
  int     checks = 0;
  int     errors = 0;
  logic   rand_stall = 1'b0;
  integer seed = 32'hb356;

  f2c_dma f2c_dma_inst (
    .clk             (clk),
    .rst             (rst),
    .flit_in_data    (flit_in_data),
    .flit_in_valid   (flit_in_valid),
    .flit_in_ready   (flit_in_ready),
    .meta_in_data    (meta_in_data),
    .meta_in_valid   (meta_in_valid),
    .meta_in_ready   (meta_in_ready),
    .pkt_rb_size     (pkt_rb_size),
    .mem_addr        (mem_addr),
    .mem_data        (mem_data),
    .mem_write       (mem_write),
    .mem_burstcount  (mem_burstcount),
    .mem_waitrequest (mem_waitrequest),
    .flit_cnt        (flit_cnt),
    .flit_drop_cnt   (flit_drop_cnt),
    .dsc_cnt         (dsc_cnt),
    .dsc_drop_cnt    (dsc_drop_cnt),
    .stall_cnt       (stall_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (rand_stall) begin
      mem_waitrequest <= (($random(seed) & 3) < 2);
    end else begin
      mem_waitrequest <= 1'b0;
    end
  end

  // Memory port model that takes address and burst count from the first beat
  always @(posedge clk) begin
    if (!rst && mem_waitrequest) begin
      stall_seen = stall_seen + 1'b1;
    end
    if (!rst && mem_write && !mem_waitrequest) begin
      if (beats_left == 0) begin
        cur_addr   = mem_addr;
        cur_bc     = mem_burstcount;
        beats_left = (mem_burstcount == '0) ? 0 : int'(mem_burstcount) - 1;
      end else begin
        beats_left = beats_left - 1;
      end
      got_addr.push_back(cur_addr);
      got_bc.push_back(cur_bc);
      got_data.push_back(mem_data);
    end
  end

  task automatic check_num(input string name, input f2c_pkg::addr_t got,
                           input f2c_pkg::addr_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input f2c_pkg::flit_t got,
                            input f2c_pkg::flit_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic f2c_pkg::pkt_meta_t make_meta(input int size, input f2c_pkg::addr_t pbase,
                                                   input int ptail, input f2c_pkg::addr_t dbase,
                                                   input int dtail, input int qid,
                                                   input logic dsc);
    f2c_pkg::pkt_meta_t m;
    m.size      = f2c_pkg::pkt_len_t'(size);
    m.pkt_base  = pbase;
    m.pkt_tail  = f2c_pkg::rb_idx_t'(ptail);
    m.dsc_base  = dbase;
    m.dsc_tail  = f2c_pkg::rb_idx_t'(dtail);
    m.queue_id  = (f2c_pkg::QID_W)'(qid);
    m.needs_dsc = dsc;
    return m;
  endfunction

  // Bursts stop at MAX_BURST, at the packet end and at the ring end
  task automatic expect_packet(input f2c_pkg::pkt_meta_t m, input int rb, input int first);
    int             remaining;
    int             tail;
    int             len;
    int             idx;
    f2c_pkg::addr_t addr;
    f2c_pkg::flit_t w;
    remaining = int'(m.size);
    tail      = int'(m.pkt_tail);
    idx       = first;
    if (m.pkt_base == '0 || m.dsc_base == '0) begin
      exp_flit_drop += f2c_pkg::cnt_t'(m.size);
      if (m.needs_dsc) begin
        exp_dsc_drop += 1;
      end
      return;
    end
    exp_flit_cnt += f2c_pkg::cnt_t'(m.size);
    while (remaining > 0) begin
      len = (remaining > f2c_pkg::MAX_BURST) ? f2c_pkg::MAX_BURST : remaining;
      if (len > rb - tail) begin
        len = rb - tail;
      end
      addr = m.pkt_base + f2c_pkg::addr_t'(f2c_pkg::FLIT_BYTES * tail);
      repeat (len) begin
        exp_addr.push_back(addr);
        exp_bc.push_back(f2c_pkg::burst_t'(len));
        exp_data.push_back(f2c_pkg::flit_t'(idx));
        idx++;
        tail = (tail + 1) % rb;
        remaining--;
      end
    end
    if (m.needs_dsc) begin
      w = '0;
      w[0] = 1'b1;
      w[f2c_pkg::RB_AWIDTH:1] = f2c_pkg::rb_idx_t'(tail);
      w[f2c_pkg::RB_AWIDTH+f2c_pkg::QID_W:f2c_pkg::RB_AWIDTH+1] = m.queue_id;
      exp_addr.push_back(m.dsc_base
                         + f2c_pkg::addr_t'(f2c_pkg::FLIT_BYTES * int'(m.dsc_tail)));
      exp_bc.push_back(f2c_pkg::burst_t'(1));
      exp_data.push_back(w);
      exp_dsc_cnt += 1;
    end
  endtask

  task automatic push_meta(input f2c_pkg::pkt_meta_t m);
    logic taken;
    @(posedge clk);
    meta_in_data  <= m;
    meta_in_valid <= 1'b1;
    do begin
      @(negedge clk);
      taken = meta_in_ready;
      @(posedge clk);
    end while (!taken);
    meta_in_valid <= 1'b0;
  endtask

  // Flit data holds its own index in the low bits
  task automatic push_flits(input int first, input int n);
    logic taken;
    int   i;
    for (i = 0; i < n; i++) begin
      flit_in_data  <= f2c_pkg::flit_t'(first + i);
      flit_in_valid <= 1'b1;
      do begin
        @(negedge clk);
        taken = flit_in_ready;
        @(posedge clk);
      end while (!taken);
    end
    flit_in_valid <= 1'b0;
  endtask

  function automatic logic packet_finished(input int n_beats);
    return (got_addr.size() - got_base == n_beats) && (flit_cnt == exp_flit_cnt)
        && (flit_drop_cnt == exp_flit_drop) && (dsc_cnt == exp_dsc_cnt)
        && (dsc_drop_cnt == exp_dsc_drop);
  endfunction

  task automatic wait_done(input int n_beats);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!packet_finished(n_beats) && cycles < DONE_LIMIT);
    checks++;
    assert (packet_finished(n_beats)) else begin
      errors++;
      $display("Timed out after %0d cycles waiting for the packet to finish", cycles);
    end
  endtask

  task automatic compare_beats();
    int n;
    int k;
    n = got_addr.size() - got_base;
    check_num("beat count", f2c_pkg::addr_t'(n), f2c_pkg::addr_t'(exp_addr.size()));
    for (k = 0; k < n && k < exp_addr.size(); k++) begin
      check_num("mem_addr", got_addr[got_base+k], exp_addr[k]);
      check_num("mem_burstcount", f2c_pkg::addr_t'(got_bc[got_base+k]),
                f2c_pkg::addr_t'(exp_bc[k]));
      check_word("mem_data", got_data[got_base+k], exp_data[k]);
    end
    got_base = got_addr.size();
    exp_addr.delete();
    exp_bc.delete();
    exp_data.delete();
  endtask

  task automatic check_counters();
    check_num("flit_cnt", f2c_pkg::addr_t'(flit_cnt), f2c_pkg::addr_t'(exp_flit_cnt));
    check_num("flit_drop_cnt", f2c_pkg::addr_t'(flit_drop_cnt), f2c_pkg::addr_t'(exp_flit_drop));
    check_num("dsc_cnt", f2c_pkg::addr_t'(dsc_cnt), f2c_pkg::addr_t'(exp_dsc_cnt));
    check_num("dsc_drop_cnt", f2c_pkg::addr_t'(dsc_drop_cnt), f2c_pkg::addr_t'(exp_dsc_drop));
    check_num("stall_cnt", f2c_pkg::addr_t'(stall_cnt), f2c_pkg::addr_t'(stall_seen));
  endtask

  // Handshake and write outputs while no packet is in flight
  task automatic check_idle_outputs(input logic ready);
    check_num("mem_write", f2c_pkg::addr_t'(mem_write), '0);
    check_num("flit_in_ready", f2c_pkg::addr_t'(flit_in_ready), f2c_pkg::addr_t'(ready));
    check_num("meta_in_ready", f2c_pkg::addr_t'(meta_in_ready), f2c_pkg::addr_t'(ready));
    check_counters();
  endtask

  task automatic run_packet(input f2c_pkg::pkt_meta_t m, input int rb);
    int first;
    first = next_flit;
    next_flit += int'(m.size);
    @(posedge clk);
    pkt_rb_size <= f2c_pkg::rb_size_t'(rb);
    expect_packet(m, rb, first);
    push_meta(m);
    push_flits(first, int'(m.size));
    wait_done(exp_addr.size());
    // A few idle cycles so stray beats show up in the count
    repeat (4) @(negedge clk);
    compare_beats();
    check_counters();
  endtask

  task automatic single_packet_with_dsc();
    run_packet(make_meta(1, 64'h1000_0000, 3, 64'h2000_0000, 5, 8'h2a, 1'b1), 64);
  endtask

  task automatic split_long_packet();
    run_packet(make_meta(20, 64'h3000_0000, 0, 64'h2000_0000, 6, 8'h11, 1'b1), 64);
  endtask

  task automatic wrap_at_ring_end();
    run_packet(make_meta(5, 64'h4000_0000, 14, 64'h2000_0000, 7, 8'h5c, 1'b1), 16);
  endtask

  task automatic drop_zero_base();
    run_packet(make_meta(6, 64'h0, 9, 64'h2000_0000, 8, 8'h03, 1'b1), 64);
  endtask

  task automatic skip_descriptor();
    run_packet(make_meta(3, 64'h5000_0000, 30, 64'h2000_0000, 9, 8'h44, 1'b0), 64);
  endtask

  task automatic stall_memory_port();
    @(posedge clk);
    rand_stall <= 1'b1;
    split_long_packet();
    wrap_at_ring_end();
    @(posedge clk);
    rand_stall <= 1'b0;
    repeat (3) @(negedge clk);
    check_counters();
  endtask

  initial begin
    rst <= 1'b1;
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_idle_outputs(1'b0);
    @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(negedge clk);
    check_idle_outputs(1'b1);
    single_packet_with_dsc();
    split_long_packet();
    wrap_at_ring_end();
    drop_zero_base();
    skip_descriptor();
    stall_memory_port();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
